//--- src/igbt_ctrl_config.svh
// ----------------------------------------
// igbt controller build constants
// clock, serial link, widths and pulse lengths
// ----------------------------------------
`ifndef IGBT_CTRL_CONFIG_SVH
`define IGBT_CTRL_CONFIG_SVH

// clock and serial link
`define CLK_FREQ          10_000_000   // sys_clk in Hz
`define UART_BPS          625_000      // 16 clocks per bit

// datapath widths
`define ADC_W             14           // adc sample bits
`define NUM_CAP           3            // capacitors and driver boards
`define NUM_GATE          5            // 3 charge + 2 discharge

// frame bytes
`define FRAME_HDR         8'hA5        // command header
`define REPLY_HDR         8'h5A        // status reply header
`define TX_CREDITS        1            // matches the tx one-byte buffer

// pulse lengths in sys_clk cycles
`define DISCHARGE_CYCLES  20
`define DRV_RESET_CYCLES  8

`endif

//--- src/uart_pkg.sv
// ----------------------------------------
// serial link types
// uart bytes, command frame, parser states
// ----------------------------------------
package uart_pkg;

   typedef logic [7:0] byte_t;   // one uart data byte

   // decoded setpoint command
   typedef struct packed {
      logic [1:0] chan;    // 1..3, capacitor 0..2
      byte_t      value;   // new setpoint
   } cmd_t;

   // frame parser
   typedef enum logic [1:0] {
      PS_HDR,     // wait for header byte
      PS_CHAN,    // wait for channel byte
      PS_VALUE    // wait for setpoint byte
   } parse_state_e;

endpackage

//--- src/igbt_pkg.sv
// ----------------------------------------
// power side types
// adc samples, setpoints, flags, gates, driver status
// ----------------------------------------
`include "igbt_ctrl_config.svh"

package igbt_pkg;
   import uart_pkg::byte_t;

   typedef logic [`ADC_W-1:0] adc_sample_t;   // unsigned adc code

   typedef struct packed {
      adc_sample_t cap2;
      adc_sample_t cap1;
      adc_sample_t cap0;    // lsbs
   } cap_samples_t;

   typedef struct packed {
      byte_t sp2;
      byte_t sp1;
      byte_t sp0;           // lsbs
   } setpoints_t;

   typedef logic [`NUM_CAP-1:0]  cap_flags_t;   // bit i = cap i reached
   typedef logic [`NUM_GATE-1:0] gate_t;        // [2:0] charge, [4:3] discharge

   typedef struct packed {
      logic [`NUM_CAP-1:0] fault;   // per driver board
      logic [`NUM_CAP-1:0] error;   // both inputs high on a board
   } drv_status_t;

   typedef enum logic [2:0] {
      PULSE_IDLE,
      PULSE_CHARGE,
      PULSE_DISCHARGE,
      PULSE_FAULT,
      PULSE_DRV_RESET
   } pulse_state_e;

endpackage

//--- src/uart_rx.sv
// ----------------------------------------
// uart receiver, 8N1
// mid-bit sampling, one strobe per good frame
// ----------------------------------------
`timescale 1ns/1ps
`include "igbt_ctrl_config.svh"

module uart_rx import uart_pkg::*; (
   input  logic  sys_clk,
   input  logic  reset,
   input  logic  uart_rxd,
   output logic  rx_valid,
   output byte_t rx_data
);

   localparam int BIT_CYCLES = `CLK_FREQ / `UART_BPS;
   localparam int CNT_W      = $clog2(BIT_CYCLES);
   localparam int HALF_BIT   = BIT_CYCLES / 2;

   logic [2:0]       rxd_sync;   // 2 sync flops + edge history
   logic             busy;
   logic [CNT_W-1:0] clk_cnt;    // position inside a bit
   logic [3:0]       bit_cnt;    // 0 start, 1..8 data, 9 stop
   logic             mid_bit;
   logic             rxd_bit;

   assign rxd_bit = rxd_sync[1];
   assign mid_bit = busy && (clk_cnt == CNT_W'(HALF_BIT));

   // ----------------------------------------
   // frame timing
   // ----------------------------------------
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         rxd_sync <= 3'b111;   // line idles high
         busy     <= 1'b0;
         clk_cnt  <= '0;
         bit_cnt  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rxd_sync <= {rxd_sync[1:0], uart_rxd};
         rx_valid <= 1'b0;
         if (!busy) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            if (rxd_sync[2:1] == 2'b10)
               busy <= 1'b1;                        // falling edge, start bit
         end else begin
            if (clk_cnt == CNT_W'(BIT_CYCLES - 1)) begin
               clk_cnt <= '0;
               bit_cnt <= bit_cnt + 4'd1;
            end else begin
               clk_cnt <= clk_cnt + 1'b1;
            end
            if (mid_bit && bit_cnt == 4'd0 && rxd_bit)
               busy <= 1'b0;                        // glitch, not a start bit
            if (mid_bit && bit_cnt == 4'd9) begin
               busy     <= 1'b0;
               rx_valid <= rxd_bit;                 // low stop bit drops the byte
            end
         end
      end
   end

   // data bits, lsb first
   always_ff @(posedge sys_clk) begin
      if (mid_bit && bit_cnt != 4'd0 && bit_cnt != 4'd9)
         rx_data <= {rxd_bit, rx_data[7:1]};
   end

endmodule

//--- src/uart_tx.sv
// ----------------------------------------
// uart transmitter, 8N1
// one-byte buffer, credit back when stop bit ends
// ----------------------------------------
`timescale 1ns/1ps
`include "igbt_ctrl_config.svh"

module uart_tx import uart_pkg::*; (
   input  logic  sys_clk,
   input  logic  reset,
   input  logic  tx_valid,
   input  byte_t tx_data,
   output logic  tx_credit,
   output logic  uart_txd
);

   localparam int BIT_CYCLES = `CLK_FREQ / `UART_BPS;
   localparam int CNT_W      = $clog2(BIT_CYCLES);

   logic             buf_full;   // byte in flight
   logic [8:0]       tx_buf;     // stop + data still to shift
   logic [CNT_W-1:0] clk_cnt;
   logic [3:0]       bit_cnt;    // bit currently on the line
   logic             bit_end;

   assign bit_end = buf_full && (clk_cnt == CNT_W'(BIT_CYCLES - 1));

   always_ff @(posedge sys_clk) begin
      if (reset) begin
         buf_full  <= 1'b0;
         uart_txd  <= 1'b1;
         clk_cnt   <= '0;
         bit_cnt   <= '0;
         tx_credit <= 1'b0;
      end else begin
         tx_credit <= 1'b0;
         if (!buf_full) begin
            if (tx_valid) begin
               buf_full <= 1'b1;
               uart_txd <= 1'b0;   // start bit next cycle
               clk_cnt  <= '0;
               bit_cnt  <= '0;
            end
         end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
               buf_full  <= 1'b0;   // stop bit done
               tx_credit <= 1'b1;   // hand the slot back
            end else begin
               bit_cnt  <= bit_cnt + 4'd1;
               uart_txd <= tx_buf[0];
            end
         end else begin
            clk_cnt <= clk_cnt + 1'b1;
         end
      end
   end

   // shift register, refilled with stop level
   always_ff @(posedge sys_clk) begin
      if (!buf_full && tx_valid)
         tx_buf <= {1'b1, tx_data};
      else if (bit_end)
         tx_buf <= {1'b1, tx_buf[8:1]};
   end

   // sender must hold off until its credit comes back
   a_no_overrun : assert property (@(posedge sys_clk) disable iff (reset)
      tx_valid |-> !buf_full);

endmodule

//--- src/cmd_parser.sv
// ----------------------------------------
// command parser
// A5 / channel / value frames set the three setpoints
// each good frame answered by 5A + status under credits
// ----------------------------------------
`timescale 1ns/1ps
`include "igbt_ctrl_config.svh"

module cmd_parser
   import uart_pkg::*;
   import igbt_pkg::*;
(
   input  logic       sys_clk,
   input  logic       reset,
   input  logic       rx_valid,
   input  byte_t      rx_data,
   input  logic       tx_credit,
   input  cap_flags_t cap_flags,
   input  logic       fault_active,
   output logic       tx_valid,
   output byte_t      tx_data,
   output setpoints_t setpoints
);

   localparam int CRED_W = $clog2(`TX_CREDITS + 1) + 1;   // spare bit for overflow

   parse_state_e      state;
   logic [1:0]        chan_q;        // channel from second byte
   cmd_t              cmd;
   logic              frame_done;
   logic [CRED_W-1:0] credit_cnt;
   logic [CRED_W-1:0] credit_next;
   logic [1:0]        pend_cnt;      // reply bytes not yet offered
   logic [1:0]        pend_eff;
   logic              send;
   byte_t             status_byte;

   always_comb begin
      cmd         = '{chan: chan_q, value: rx_data};
      frame_done  = rx_valid && (state == PS_VALUE);
      credit_next = credit_cnt + CRED_W'(tx_credit) - CRED_W'(tx_valid);
      pend_eff    = (frame_done && pend_cnt == 2'd0) ? 2'd2 : pend_cnt;   // busy reply drops new one
      send        = (pend_eff != 2'd0) && (credit_next != '0);
      status_byte = {4'b0000, fault_active, cap_flags};
   end

   // ----------------------------------------
   // frame fsm, setpoints, reply queue
   // ----------------------------------------
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         state      <= PS_HDR;
         chan_q     <= '0;
         credit_cnt <= CRED_W'(`TX_CREDITS);
         pend_cnt   <= '0;
         tx_valid   <= 1'b0;
         setpoints  <= '0;
      end else begin
         credit_cnt <= credit_next;
         pend_cnt   <= pend_eff - {1'b0, send};
         tx_valid   <= send;
         if (rx_valid) begin
            case (state)
               PS_HDR:   if (rx_data == `FRAME_HDR) state <= PS_CHAN;
               PS_CHAN: begin
                  chan_q <= rx_data[1:0];
                  state  <= (rx_data inside {8'd1, 8'd2, 8'd3}) ? PS_VALUE : PS_HDR;
               end
               default:  state <= PS_HDR;   // value byte closes the frame
            endcase
         end
         if (frame_done) begin
            case (cmd.chan)
               2'd1:    setpoints.sp0 <= cmd.value;
               2'd2:    setpoints.sp1 <= cmd.value;
               default: setpoints.sp2 <= cmd.value;
            endcase
         end
      end
   end

   // header first, status at its own send time
   always_ff @(posedge sys_clk) begin
      if (send)
         tx_data <= (pend_eff == 2'd2) ? `REPLY_HDR : status_byte;
   end

   // transmitter must never return more than it was lent
   a_credit_bound : assert property (@(posedge sys_clk) disable iff (reset)
      credit_cnt <= CRED_W'(`TX_CREDITS));

endmodule

//--- src/cap_monitor.sv
// ----------------------------------------
// capacitor voltage monitor
// flags each cap once its sample reaches the setpoint
// ----------------------------------------
`timescale 1ns/1ps
`include "igbt_ctrl_config.svh"

module cap_monitor
   import uart_pkg::*;
   import igbt_pkg::*;
(
   input  logic         sys_clk,
   input  logic         reset,
   input  logic         adc_valid,
   input  cap_samples_t adc_samples,
   input  setpoints_t   setpoints,
   output cap_flags_t   cap_flags
);

   // upper byte of the sample against the 8-bit setpoint
   function automatic logic reached(adc_sample_t sample, byte_t sp);
      return sample[`ADC_W-1 -: 8] >= sp;
   endfunction

   always_ff @(posedge sys_clk) begin
      if (reset) begin
         cap_flags <= '0;
      end else if (adc_valid) begin   // hold between sample sets
         cap_flags <= {reached(adc_samples.cap2, setpoints.sp2),
                       reached(adc_samples.cap1, setpoints.sp1),
                       reached(adc_samples.cap0, setpoints.sp0)};
      end
   end

endmodule

//--- src/pulse_ctrl.sv
// ----------------------------------------
// pulse control fsm
// charge / discharge gates, driver faults, driver reset pulse
// ----------------------------------------
`timescale 1ns/1ps
`include "igbt_ctrl_config.svh"

module pulse_ctrl import igbt_pkg::*; (
   input  logic                sys_clk,
   input  logic                reset,
   input  logic [3:0]          key,
   input  drv_status_t         drv_status,
   input  cap_flags_t          cap_flags,
   output gate_t               gate,
   output logic [`NUM_CAP-1:0] drv_reset,
   output logic                fault_active
);

   localparam int MAX_CYC = (`DISCHARGE_CYCLES > `DRV_RESET_CYCLES) ?
                            `DISCHARGE_CYCLES : `DRV_RESET_CYCLES;
   localparam int CNT_W   = $clog2(MAX_CYC);

   logic [3:0]          key_s1, key_s2, key_d;
   logic [3:0]          key_rise;
   drv_status_t         drv_s1, drv_s2;
   logic                fault_any;
   logic [`NUM_CAP-1:0] charge_req;
   logic [1:0]          charge_sel;
   logic [1:0]          cap_sel;      // cap being charged
   logic [CNT_W-1:0]    cnt;          // discharge / reset length
   pulse_state_e        state;

   // ----------------------------------------
   // input sync and edge detect
   // ----------------------------------------
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         key_s1 <= '0;
         key_s2 <= '0;
         key_d  <= '0;
         drv_s1 <= '0;
         drv_s2 <= '0;
      end else begin
         key_s1 <= key;
         key_s2 <= key_s1;
         key_d  <= key_s2;
         drv_s1 <= drv_status;
         drv_s2 <= drv_s1;
      end
   end

   assign key_rise  = key_s2 & ~key_d;
   assign fault_any = |drv_s2;   // any fault or error bit

   // lowest key wins, skip caps already charged
   always_comb begin
      charge_req = key_rise[`NUM_CAP-1:0] & ~cap_flags;
      charge_sel = '0;
      for (int i = `NUM_CAP - 1; i >= 0; i--)
         if (charge_req[i]) charge_sel = 2'(i);
   end

   // ----------------------------------------
   // control fsm
   // ----------------------------------------
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         state   <= PULSE_IDLE;
         cap_sel <= '0;
         cnt     <= '0;
      end else if (fault_any) begin
         state <= PULSE_FAULT;   // from any state
         cnt   <= '0;
      end else begin
         cnt <= cnt + 1'b1;
         case (state)
            PULSE_IDLE: begin
               cnt <= '0;
               if (|charge_req) begin
                  state   <= PULSE_CHARGE;
                  cap_sel <= charge_sel;
               end else if (key_rise[3]) begin
                  state <= PULSE_DISCHARGE;
               end
            end
            PULSE_CHARGE:    if (cap_flags[cap_sel]) state <= PULSE_IDLE;
            PULSE_DISCHARGE: if (cnt == CNT_W'(`DISCHARGE_CYCLES - 1)) state <= PULSE_IDLE;
            PULSE_FAULT: begin
               cnt   <= '0;
               state <= PULSE_DRV_RESET;   // status clear now
            end
            default:         if (cnt == CNT_W'(`DRV_RESET_CYCLES - 1)) state <= PULSE_IDLE;
         endcase
      end
   end

   // gates decoded straight from state
   always_comb begin
      gate = '0;
      case (state)
         PULSE_CHARGE:    gate[cap_sel] = 1'b1;
         PULSE_DISCHARGE: gate[`NUM_GATE-1 -: 2] = 2'b11;
         default:         gate = '0;
      endcase
   end

   assign drv_reset    = {`NUM_CAP{state == PULSE_DRV_RESET}};
   assign fault_active = (state == PULSE_FAULT);

   // charging into a discharging bank shorts the supply
   a_gate_excl : assert property (@(posedge sys_clk) disable iff (reset)
      !(|gate[`NUM_CAP-1:0] && |gate[`NUM_GATE-1 -: 2]));

endmodule

//--- src/igbt_ctrl_top.sv
// ----------------------------------------
// igbt charge / discharge controller top
// uart link and cap monitor around the pulse fsm
// ----------------------------------------
`timescale 1ns/1ps
`include "igbt_ctrl_config.svh"

module igbt_ctrl_top
   import uart_pkg::*;
   import igbt_pkg::*;
(
   input  logic                sys_clk,
   input  logic                reset,
   input  logic                uart_rxd,
   output logic                uart_txd,
   input  logic [3:0]          key,
   input  logic                adc_valid,
   input  cap_samples_t        adc_samples,
   input  drv_status_t         drv_status,
   output gate_t               gate,
   output logic [`NUM_CAP-1:0] drv_reset
);

   // link path
   logic       rx_valid;
   byte_t      rx_data;
   logic       tx_valid;
   byte_t      tx_data;
   logic       tx_credit;
   // power path
   setpoints_t setpoints;
   cap_flags_t cap_flags;
   logic       fault_active;

   uart_rx u_uart_rx (
      .sys_clk  (sys_clk),
      .reset    (reset),
      .uart_rxd (uart_rxd),
      .rx_valid (rx_valid),
      .rx_data  (rx_data)
   );

   uart_tx u_uart_tx (
      .sys_clk   (sys_clk),
      .reset     (reset),
      .tx_valid  (tx_valid),
      .tx_data   (tx_data),
      .tx_credit (tx_credit),
      .uart_txd  (uart_txd)
   );

   cmd_parser u_cmd_parser (
      .sys_clk      (sys_clk),
      .reset        (reset),
      .rx_valid     (rx_valid),
      .rx_data      (rx_data),
      .tx_credit    (tx_credit),
      .cap_flags    (cap_flags),
      .fault_active (fault_active),
      .tx_valid     (tx_valid),
      .tx_data      (tx_data),
      .setpoints    (setpoints)
   );

   cap_monitor u_cap_monitor (
      .sys_clk     (sys_clk),
      .reset       (reset),
      .adc_valid   (adc_valid),
      .adc_samples (adc_samples),
      .setpoints   (setpoints),
      .cap_flags   (cap_flags)
   );

   pulse_ctrl u_pulse_ctrl (
      .sys_clk      (sys_clk),
      .reset        (reset),
      .key          (key),
      .drv_status   (drv_status),
      .cap_flags    (cap_flags),
      .gate         (gate),
      .drv_reset    (drv_reset),
      .fault_active (fault_active)
   );

endmodule

//--- testbench/tb_igbt_ctrl.sv
// ----------------------------------------
// igbt controller testbench
// uart frames, adc samples, keys and driver faults
// ----------------------------------------
`timescale 1ns/1ps
`include "igbt_ctrl_config.svh"

module tb_igbt_ctrl
   import uart_pkg::*;
   import igbt_pkg::*;
();

   localparam int BIT_CLKS      = `CLK_FREQ / `UART_BPS;   // clocks per uart bit
   localparam int REPLY_TIMEOUT = 40 * BIT_CLKS;           // frame in + reply start

   logic         sys_clk;
   logic         reset;
   logic         uart_rxd;
   logic         uart_txd;
   logic [3:0]   key;
   logic         adc_valid;
   cap_samples_t adc_samples;
   drv_status_t  drv_status;
   gate_t        gate;
   logic [2:0]   drv_reset;

   logic [31:0]  rand_state = 32'h33a2;   // lcg seed
   string        cur_test   = "reset";

   igbt_ctrl_top uut (
      .sys_clk     (sys_clk),
      .reset       (reset),
      .uart_rxd    (uart_rxd),
      .uart_txd    (uart_txd),
      .key         (key),
      .adc_valid   (adc_valid),
      .adc_samples (adc_samples),
      .drv_status  (drv_status),
      .gate        (gate),
      .drv_reset   (drv_reset)
   );

   initial begin
      sys_clk = 1'b0;
      forever #50 sys_clk = ~sys_clk;   // 100 ns period
   end

   // ----------------------------------------
   // reporting and helpers
   // ----------------------------------------
   task automatic stop_run();
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_mismatch(input string what, input int expected, input int actual);
      $display("error %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
      stop_run();
   endtask

   task automatic report_failure(input string text);
      $display("%s: %s", cur_test, text);
      stop_run();
   endtask

   function automatic logic [31:0] next_random();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state >> 8;   // low lcg bits are weak
   endfunction

   // one 8N1 byte into the DUT, lsb first
   task automatic send_byte(input byte_t data);
      int i;
      uart_rxd = 1'b0;   // start bit
      repeat (BIT_CLKS) @(negedge sys_clk);
      for (i = 0; i < 8; i++) begin
         uart_rxd = data[i];
         repeat (BIT_CLKS) @(negedge sys_clk);
      end
      uart_rxd = 1'b1;   // stop bit
      repeat (BIT_CLKS) @(negedge sys_clk);
   endtask

   // one byte from the DUT, sampled mid-bit
   task automatic recv_byte(output byte_t data);
      int n;
      int i;
      n = 0;
      while (uart_txd !== 1'b0 && n < REPLY_TIMEOUT) begin
         @(negedge sys_clk);
         n++;
      end
      assert (uart_txd === 1'b0) else report_failure("no start bit from the DUT transmitter");
      repeat (BIT_CLKS / 2) @(negedge sys_clk);
      assert (uart_txd === 1'b0) else report_failure("start bit from the DUT did not hold");
      for (i = 0; i < 8; i++) begin
         repeat (BIT_CLKS) @(negedge sys_clk);
         data[i] = uart_txd;
      end
      repeat (BIT_CLKS) @(negedge sys_clk);
      assert (uart_txd === 1'b1) else report_failure("stop bit from the DUT was low");
   endtask

   // full command frame, reply collected while it goes out
   task automatic send_frame_get_reply(input byte_t chan, input byte_t value,
                                       output byte_t status);
      byte_t hdr;
      fork
         begin
            send_byte(`FRAME_HDR);
            send_byte(chan);
            send_byte(value);
         end
         begin
            recv_byte(hdr);
            recv_byte(status);
         end
      join
      assert (hdr == `REPLY_HDR) else report_mismatch("reply header", `REPLY_HDR, hdr);
   endtask

   task automatic drive_adc(input adc_sample_t s0, input adc_sample_t s1, input adc_sample_t s2);
      adc_samples.cap0 = s0;
      adc_samples.cap1 = s1;
      adc_samples.cap2 = s2;
      adc_valid        = 1'b1;
      @(negedge sys_clk);
      adc_valid = 1'b0;
   endtask

   // wait until the masked gates match, bounded
   task automatic wait_gates(input gate_t mask, input gate_t value, input int limit,
                             input string what);
      int n;
      n = 0;
      while ((gate & mask) !== value && n < limit) begin
         @(negedge sys_clk);
         n++;
      end
      assert ((gate & mask) === value) else report_failure({"timed out waiting for ", what});
   endtask

   // ----------------------------------------
   // directed tests
   // ----------------------------------------
   task automatic check_setpoint_reply();
      byte_t       sp;
      byte_t       upper;
      byte_t       status;
      adc_sample_t sample;
      logic        exp_flag;
      int          pass;
      cur_test = "setpoint_reply";
      sp = 8'h20 + 8'(next_random() % 32'hC0);
      send_frame_get_reply(8'd1, sp, status);
      for (pass = 0; pass < 2; pass++) begin
         if (pass == 0)
            upper = sp - 8'd1 - 8'(next_random() % 8);   // below setpoint
         else
            upper = sp + 8'(next_random() % 16);         // at or above
         sample   = {upper, 6'(next_random())};
         exp_flag = (upper >= sp);                       // upper byte against setpoint
         drive_adc(sample, '0, '0);
         send_frame_get_reply(8'd1, sp, status);          // same value, just a status poll
         assert (status[0] == exp_flag) else report_mismatch("status bit 0", exp_flag, status[0]);
         assert (status[7:3] == 5'd0) else report_mismatch("status bits 7:3", 0, status[7:3]);
      end
   endtask

   task automatic reject_bad_channel();
      byte_t bad_chan [2];
      byte_t status;
      int    i;
      int    n;
      cur_test    = "bad_channel";
      bad_chan[0] = 8'd0;
      bad_chan[1] = 8'd4;
      for (i = 0; i < 2; i++) begin
         send_byte(`FRAME_HDR);
         send_byte(bad_chan[i]);
         send_byte(8'(next_random()) & 8'h7F);   // never a header byte
         for (n = 0; n < 20 * BIT_CLKS; n++) begin
            assert (uart_txd === 1'b1) else report_failure("DUT replied to a bad channel byte");
            @(negedge sys_clk);
         end
      end
      send_frame_get_reply(8'd3, 8'(next_random()), status);   // parser still alive
   endtask

   task automatic run_charge();
      byte_t sp;
      byte_t status;
      cur_test = "charge";
      sp = 8'h40 + 8'(next_random() % 32'h80);
      send_frame_get_reply(8'd1, sp, status);
      drive_adc({sp - 8'd1, 6'h3F}, '0, '0);   // just under
      key[0] = 1'b1;
      wait_gates(5'b00001, 5'b00001, 6, "gate 0 to rise");
      assert (gate == 5'b00001) else report_mismatch("gates while charging", 5'b00001, gate);
      key[0] = 1'b0;
      @(negedge sys_clk);
      drive_adc({sp, 6'h00}, '0, '0);          // exactly at setpoint
      wait_gates(5'b00001, 5'b00000, 4, "gate 0 to fall");
      assert (gate == 5'b00000) else report_mismatch("gates after charge", 0, gate);
   endtask

   task automatic run_discharge();
      int cycles;
      cur_test = "discharge";
      key[3] = 1'b1;
      wait_gates(5'b11000, 5'b11000, 6, "discharge gates to rise");
      cycles = 0;
      while (gate[4:3] == 2'b11 && cycles <= `DISCHARGE_CYCLES + 4) begin
         assert (gate[2:0] == 3'b000) else report_mismatch("charge gates", 0, gate[2:0]);
         cycles++;
         @(negedge sys_clk);
      end
      assert (cycles == `DISCHARGE_CYCLES)
         else report_mismatch("discharge length", `DISCHARGE_CYCLES, cycles);
      key[3] = 1'b0;
      @(negedge sys_clk);
   endtask

   task automatic run_fault_recovery();
      byte_t sp;
      byte_t status;
      int    n;
      int    cycles;
      cur_test = "fault";
      sp = 8'h40 + 8'(next_random() % 32'h80);
      send_frame_get_reply(8'd2, sp, status);
      drive_adc('0, {sp - 8'd2, 6'h00}, '0);   // cap 1 still low
      key[1] = 1'b1;
      wait_gates(5'b00010, 5'b00010, 6, "gate 1 to rise");
      key[1] = 1'b0;
      drv_status.fault[1] = 1'b1;              // driver board 1 trips
      wait_gates(5'b11111, 5'b00000, 4, "all gates off on fault");
      send_frame_get_reply(8'd2, sp, status);
      assert (status[3] == 1'b1) else report_mismatch("status fault bit", 1, status[3]);
      assert (status[7:4] == 4'd0) else report_mismatch("status bits 7:4", 0, status[7:4]);
      drv_status = '0;
      n = 0;
      while (drv_reset !== 3'b111 && n < 6) begin
         @(negedge sys_clk);
         n++;
      end
      assert (drv_reset === 3'b111) else report_failure("driver reset never rose");
      cycles = 0;
      while (drv_reset == 3'b111 && cycles <= `DRV_RESET_CYCLES + 4) begin
         assert (gate == 5'b00000) else report_mismatch("gates in driver reset", 0, gate);
         cycles++;
         @(negedge sys_clk);
      end
      assert (cycles == `DRV_RESET_CYCLES)
         else report_mismatch("driver reset length", `DRV_RESET_CYCLES, cycles);
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      reset       = 1'b1;
      uart_rxd    = 1'b1;   // line idle
      key         = '0;
      adc_valid   = 1'b0;
      adc_samples = '0;
      drv_status  = '0;
      repeat (10) @(negedge sys_clk);
      reset = 1'b0;
      @(negedge sys_clk);
      check_setpoint_reply();
      reject_bad_channel();
      run_charge();
      run_discharge();
      run_fault_recovery();
      repeat (2 * BIT_CLKS) @(negedge sys_clk);   // let the last stop bit finish
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

//--- tb.f
+incdir+src
src/uart_pkg.sv
src/igbt_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_parser.sv
src/cap_monitor.sv
src/pulse_ctrl.sv
src/igbt_ctrl_top.sv
testbench/tb_igbt_ctrl.sv

//--- Bender.yml
package:
  name: igbt_ctrl

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/uart_pkg.sv
      - src/igbt_pkg.sv
      - src/uart_rx.sv
      - src/uart_tx.sv
      - src/cmd_parser.sv
      - src/cap_monitor.sv
      - src/pulse_ctrl.sv
      - src/igbt_ctrl_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - testbench/tb_igbt_ctrl.sv
